// ==== Makefile ====
# Verilator build and run of the motor drive testbench

VERILATOR ?= verilator
TOP       ?= motor_drive_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and write $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables that can be set on the command line:"
	@echo "  VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/motor_drive_top.sv ====
`timescale 1ns/1ps

module motor_drive_top #(
    parameter int PERIOD = 4000
) (
    input logic clk,
    input logic reset,
    input motor_pkg::mode_t mode,
    output logic [1:0] pwm,   // left wheel in bit 1, right wheel in bit 0
    output logic frame
);

    motor_pkg::count_t count;

    wheel_if left_bus ();
    wheel_if right_bus ();

    pwm_timebase #(
        .PERIOD(PERIOD)
    ) timebase (
        .clk(clk),
        .reset(reset),
        .count(count),
        .frame(frame)
    );

    // both wheels see the same frame counter and strobe
    assign left_bus.frame = frame;
    assign left_bus.count = count;
    assign right_bus.frame = frame;
    assign right_bus.count = count;

    steer_control steering (
        .left(left_bus.ctrl),
        .right(right_bus.ctrl),
        .mode(mode)
    );

    wheel_channel #(
        .PERIOD(PERIOD)
    ) left_wheel (
        .clk(clk),
        .reset(reset),
        .bus(left_bus.wheel),
        .pwm(pwm[1])
    );

    wheel_channel #(
        .PERIOD(PERIOD)
    ) right_wheel (
        .clk(clk),
        .reset(reset),
        .bus(right_bus.wheel),
        .pwm(pwm[0])
    );

endmodule

// ==== design/motor_pkg.sv ====
package motor_pkg;

    typedef logic [9:0] duty_t;          // wheel duty, 1023 is full drive
    typedef logic [11:0] count_t;        // frame counter and pwm threshold
    typedef logic [2:0] mode_t;          // steering mode from the line sensor logic
    typedef logic [2:0] wheel_action_t;  // ramp step applied to one wheel per frame

    // ramp actions, one per wheel and frame
    localparam wheel_action_t ACT_BOOST = 3'd0;     // fast climb toward full duty
    localparam wheel_action_t ACT_INC = 3'd1;
    localparam wheel_action_t ACT_DEC = 3'd2;
    localparam wheel_action_t ACT_CUT = 3'd3;       // fast drop toward zero
    localparam wheel_action_t ACT_SET_MAX = 3'd4;
    localparam wheel_action_t ACT_SET_ZERO = 3'd5;

    // steering modes, 010 and 101 fall through to full speed on both wheels
    localparam mode_t MODE_FORWARD = 3'b000;
    localparam mode_t MODE_VEER_LEFT = 3'b001;
    localparam mode_t MODE_SPIN_LEFT = 3'b011;
    localparam mode_t MODE_VEER_RIGHT = 3'b100;
    localparam mode_t MODE_SPIN_RIGHT = 3'b110;
    localparam mode_t MODE_PIVOT = 3'b111;

    // ramp constants
    localparam duty_t DUTY_MAX = 10'd1023;
    localparam duty_t BOOST_STEP = 10'd23;
    localparam duty_t BOOST_LIMIT = 10'd1000;  // above this a boost snaps to full duty
    localparam duty_t CUT_STEP = 10'd50;

endpackage

// ==== design/pwm_timebase.sv ====
`timescale 1ns/1ps

module pwm_timebase #(
    parameter int PERIOD = 4000
) (
    input logic clk,
    input logic reset,
    output motor_pkg::count_t count,
    output logic frame
);

    localparam motor_pkg::count_t LAST = motor_pkg::count_t'(PERIOD - 1);

    motor_pkg::count_t count_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= '0;
        end else if (count_q == LAST) begin
            count_q <= '0;  // wrap closes the frame
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count = count_q;
    assign frame = (count_q == LAST);  // the duty update lands on the edge that wraps count

    // the counter never leaves the frame range
    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count_q <= LAST
    ) else $error("frame counter past the end of the frame");

    // with at least two clocks per frame the strobe is isolated
    frame_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        frame |=> !frame
    ) else $error("frame strobe high on consecutive cycles");

endmodule

// ==== design/steer_control.sv ====
`timescale 1ns/1ps

module steer_control (
    wheel_if.ctrl left,
    wheel_if.ctrl right,
    input motor_pkg::mode_t mode
);

    motor_pkg::wheel_action_t left_act;
    motor_pkg::wheel_action_t right_act;
    logic left_faster;

    assign left_faster = (left.duty > right.duty);  // a tie counts as right being faster

    always_comb begin
        left_act = motor_pkg::ACT_SET_MAX;
        right_act = motor_pkg::ACT_SET_MAX;
        case (mode)
            motor_pkg::MODE_FORWARD: begin
                left_act = motor_pkg::ACT_BOOST;
                right_act = motor_pkg::ACT_BOOST;
            end
            motor_pkg::MODE_VEER_LEFT: begin
                left_act = motor_pkg::ACT_DEC;
                right_act = motor_pkg::ACT_INC;
            end
            motor_pkg::MODE_SPIN_LEFT: begin
                left_act = motor_pkg::ACT_CUT;  // inner wheel drops hard
                right_act = motor_pkg::ACT_DEC;
            end
            motor_pkg::MODE_VEER_RIGHT: begin
                left_act = motor_pkg::ACT_INC;
                right_act = motor_pkg::ACT_DEC;
            end
            motor_pkg::MODE_SPIN_RIGHT: begin
                left_act = motor_pkg::ACT_DEC;
                right_act = motor_pkg::ACT_CUT;
            end
            motor_pkg::MODE_PIVOT: begin
                // the faster wheel takes full drive and the other one stops
                if (left_faster) begin
                    left_act = motor_pkg::ACT_SET_MAX;
                    right_act = motor_pkg::ACT_SET_ZERO;
                end else begin
                    left_act = motor_pkg::ACT_SET_ZERO;
                    right_act = motor_pkg::ACT_SET_MAX;
                end
            end
            default: begin
                left_act = motor_pkg::ACT_SET_MAX;  // unused codes run both wheels flat out
                right_act = motor_pkg::ACT_SET_MAX;
            end
        endcase
    end

    assign left.action = left_act;
    assign right.action = right_act;

endmodule

// ==== design/wheel_channel.sv ====
`timescale 1ns/1ps

module wheel_channel #(
    parameter int PERIOD = 4000
) (
    input logic clk,
    input logic reset,
    wheel_if.wheel bus,
    output logic pwm
);

    localparam int DUTY_W = $bits(motor_pkg::duty_t);
    localparam int PROD_W = DUTY_W + $bits(motor_pkg::count_t);

    motor_pkg::duty_t duty_q;
    motor_pkg::duty_t next_duty;
    logic [PROD_W-1:0] product;
    motor_pkg::count_t threshold;

    // saturating ramp for the requested action
    always_comb begin
        next_duty = duty_q;
        case (bus.action)
            motor_pkg::ACT_BOOST: begin
                if (duty_q > motor_pkg::BOOST_LIMIT) begin
                    next_duty = motor_pkg::DUTY_MAX;
                end else begin
                    next_duty = duty_q + motor_pkg::BOOST_STEP;  // tops out at exactly 1023
                end
            end
            motor_pkg::ACT_INC: begin
                if (duty_q != motor_pkg::DUTY_MAX) begin
                    next_duty = duty_q + 1'b1;
                end
            end
            motor_pkg::ACT_DEC: begin
                if (duty_q != '0) begin
                    next_duty = duty_q - 1'b1;
                end
            end
            motor_pkg::ACT_CUT: begin
                if (duty_q > motor_pkg::CUT_STEP) begin
                    next_duty = duty_q - motor_pkg::CUT_STEP;
                end else begin
                    next_duty = '0;
                end
            end
            motor_pkg::ACT_SET_MAX: begin
                next_duty = motor_pkg::DUTY_MAX;
            end
            motor_pkg::ACT_SET_ZERO: begin
                next_duty = '0;
            end
            default: begin
                next_duty = duty_q;  // spare codes hold the duty
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            duty_q <= motor_pkg::DUTY_MAX;  // wheels start at full drive
        end else if (bus.frame) begin
            duty_q <= next_duty;
        end
    end

    assign bus.duty = duty_q;

    // threshold is PERIOD * duty / 1024, which always fits the counter width
    assign product = PROD_W'(PERIOD) * PROD_W'(duty_q);
    assign threshold = motor_pkg::count_t'(product >> DUTY_W);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (bus.count < threshold);  // high for the first threshold counts of a frame
        end
    end

    // a duty of zero on the previous cycle means no drive at all on this one
    zero_duty_no_drive: assert property (
        @(posedge clk) disable iff (reset)
        ($past(duty_q) == '0) |-> !pwm
    ) else $error("pwm high while the wheel duty is zero");

endmodule

// ==== design/wheel_if.sv ====
`timescale 1ns/1ps

interface wheel_if;

    logic frame;                          // one-cycle strobe at the last count of a frame
    motor_pkg::wheel_action_t action;     // valid whenever frame is high
    motor_pkg::duty_t duty;               // current duty held by the wheel
    motor_pkg::count_t count;             // shared frame counter

    modport ctrl (
        output action,
        input duty
    );

    modport wheel (
        input frame,
        input action,
        input count,
        output duty
    );

endinterface

// ==== list.f ====
design/motor_pkg.sv
design/wheel_if.sv
design/pwm_timebase.sv
design/wheel_channel.sv
design/steer_control.sv
design/motor_drive_top.sv
verif/motor_drive_tb.sv

// ==== verif/motor_drive_tb.sv ====
`timescale 1ns/1ps

module motor_drive_tb;

    localparam int PERIOD = 400;
    localparam int RESET_CYCLES = 8;
    localparam int DUTY_FULL = 1023;

    // steering mode codes
    localparam logic [2:0] FORWARD = 3'b000;
    localparam logic [2:0] VEER_LEFT = 3'b001;
    localparam logic [2:0] FULL_SPEED = 3'b010;
    localparam logic [2:0] SPIN_LEFT = 3'b011;
    localparam logic [2:0] VEER_RIGHT = 3'b100;
    localparam logic [2:0] FULL_SPEED_ALT = 3'b101;
    localparam logic [2:0] SPIN_RIGHT = 3'b110;
    localparam logic [2:0] PIVOT = 3'b111;

    // ramp steps of the reference model
    localparam int STEP_BOOST = 0;
    localparam int STEP_INC = 1;
    localparam int STEP_DEC = 2;
    localparam int STEP_CUT = 3;
    localparam int STEP_MAX = 4;
    localparam int STEP_ZERO = 5;

    logic clk;
    logic reset;
    logic [2:0] mode;
    logic [1:0] pwm;
    logic frame;

    int model_left;     // reference duties
    int model_right;
    bit synced;         // set once the model has taken the strobe that opens the current frame
    int last_left;      // high cycles of the last measured frame
    int last_right;
    logic [15:0] lfsr;

    motor_drive_top #(
        .PERIOD(PERIOD)
    ) dut (
        .clk(clk),
        .reset(reset),
        .mode(mode),
        .pwm(pwm),
        .frame(frame)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("Fail at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int threshold(input int duty);
        return (PERIOD * duty) / 1024;
    endfunction

    function automatic int ramp(input int duty, input int step);
        case (step)
            STEP_BOOST: return (duty > 1000) ? DUTY_FULL : duty + 23;
            STEP_INC: return (duty < DUTY_FULL) ? duty + 1 : DUTY_FULL;
            STEP_DEC: return (duty > 0) ? duty - 1 : 0;
            STEP_CUT: return (duty > 50) ? duty - 50 : 0;
            STEP_ZERO: return 0;
            default: return DUTY_FULL;
        endcase
    endfunction

    // one frame update of both reference duties
    task automatic model_step(input logic [2:0] m);
        int step_left;
        int step_right;
        step_left = STEP_MAX;
        step_right = STEP_MAX;  // unused codes run both wheels at full speed
        case (m)
            FORWARD: begin
                step_left = STEP_BOOST;
                step_right = STEP_BOOST;
            end
            VEER_LEFT: begin
                step_left = STEP_DEC;
                step_right = STEP_INC;
            end
            SPIN_LEFT: begin
                step_left = STEP_CUT;
                step_right = STEP_DEC;
            end
            VEER_RIGHT: begin
                step_left = STEP_INC;
                step_right = STEP_DEC;
            end
            SPIN_RIGHT: begin
                step_left = STEP_DEC;
                step_right = STEP_CUT;
            end
            PIVOT: begin
                step_left = (model_left > model_right) ? STEP_MAX : STEP_ZERO;
                step_right = (model_left > model_right) ? STEP_ZERO : STEP_MAX;
            end
            default: begin
            end
        endcase
        model_left = ramp(model_left, step_left);
        model_right = ramp(model_right, step_right);
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_mode(output logic [2:0] m);
        m = 3'b000;
        for (int i = 0; i < 3; i++) begin
            m = {m[1:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);  // one step for each bit taken
        end
    endtask

    task automatic apply_reset(input logic [2:0] hold_mode);
        reset = 1'b1;
        mode = hold_mode;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value((pwm === 2'b00) ? 1 : 0, 1, "pwm low during reset");
            check_value((frame === 1'b0) ? 1 : 0, 1, "frame low during reset");
        end
        reset = 1'b0;
        model_left = DUTY_FULL;
        model_right = DUTY_FULL;
        synced = 1'b0;
    endtask

    task automatic wait_frame();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (frame !== 1'b1 && waited < 2 * PERIOD);
        if (frame !== 1'b1) begin
            $display("timed out waiting for the frame strobe");
            $display("test failed");
            $fatal(1, "frame strobe timeout");
        end
    endtask

    // the duty in the measured frame comes from the strobe before it
    // and next_mode is what the strobe inside the window takes
    task automatic measure_frame(input logic [2:0] next_mode);
        int high_left;
        int high_right;
        int strobes;
        if (!synced) begin
            wait_frame();
            model_step(mode);
            @(negedge clk);
            synced = 1'b1;
        end
        mode = next_mode;
        high_left = 0;
        high_right = 0;
        strobes = 0;
        repeat (PERIOD) begin
            @(negedge clk);
            if (pwm[1] === 1'b1) high_left++;
            if (pwm[0] === 1'b1) high_right++;
            if (frame === 1'b1) strobes++;
        end
        check_value(high_left, threshold(model_left), "left pwm high cycles");
        check_value(high_right, threshold(model_right), "right pwm high cycles");
        check_value(strobes, 1, "frame strobes in one frame");
        last_left = high_left;
        last_right = high_right;
        model_step(next_mode);
    endtask

    task automatic test_reset_full_speed();
        apply_reset(FULL_SPEED);
        repeat (3) measure_frame(FULL_SPEED);
        repeat (2) measure_frame(FULL_SPEED_ALT);
        check_value(last_left, threshold(DUTY_FULL), "left full speed highs");
        check_value(last_right, threshold(DUTY_FULL), "right full speed highs");
    endtask

    task automatic test_forward_ramp();
        repeat (6) measure_frame(SPIN_LEFT);
        repeat (16) measure_frame(FORWARD);  // boosts back up and snaps to full
        check_value(last_left, threshold(DUTY_FULL), "left after forward ramp");
        check_value(last_right, threshold(DUTY_FULL), "right after forward ramp");
    endtask

    task automatic test_veer_spin();
        repeat (5) measure_frame(VEER_RIGHT);   // left clamps at full
        repeat (24) measure_frame(SPIN_LEFT);
        check_value(last_left, 0, "left after spin left");
        repeat (10) measure_frame(VEER_LEFT);
        check_value(last_left, 0, "left after veer left");
        repeat (24) measure_frame(SPIN_RIGHT);
        check_value(last_right, 0, "right after spin right");
        repeat (10) measure_frame(VEER_RIGHT);
        check_value(last_right, 0, "right after veer right");
    endtask

    task automatic test_pivot();
        repeat (3) measure_frame(FULL_SPEED);
        repeat (4) measure_frame(VEER_RIGHT);
        repeat (3) measure_frame(PIVOT);
        check_value(last_left, threshold(DUTY_FULL), "left after pivot, left faster");
        check_value(last_right, 0, "right after pivot, left faster");
        repeat (3) measure_frame(FULL_SPEED);
        repeat (4) measure_frame(VEER_LEFT);
        repeat (3) measure_frame(PIVOT);
        check_value(last_left, 0, "left after pivot, right faster");
        check_value(last_right, threshold(DUTY_FULL), "right after pivot, right faster");
        apply_reset(PIVOT);  // equal duties out of reset
        repeat (2) measure_frame(PIVOT);
        check_value(last_left, 0, "left after pivot tie");
        check_value(last_right, threshold(DUTY_FULL), "right after pivot tie");
    endtask

    task automatic test_random_modes();
        logic [2:0] m;
        repeat (40) begin
            random_mode(m);
            measure_frame(m);
        end
    endtask

    initial begin
        reset = 1'b1;
        mode = FULL_SPEED;
        lfsr = 16'd74;
        model_left = DUTY_FULL;
        model_right = DUTY_FULL;
        synced = 1'b0;
        last_left = 0;
        last_right = 0;
        test_reset_full_speed();
        test_forward_ramp();
        test_veer_spin();
        test_pivot();
        test_random_modes();
        $display("test passed");
        $finish;
    end

endmodule
